// ==== logic/pid_params.svh ====
`ifndef PID_PARAMS_SVH
`define PID_PARAMS_SVH

// channel count and data widths
`define N_CHAN    2                     // servo channels
`define W_ADC     18                    // adc sample, signed
`define W_COMP    64                    // pid computation width
`define W_EP      16                    // host word and wishbone data
`define W_DAC     16                    // dac word, signed
`define OSM_MAX   8                     // largest oversample exponent
`define W_ACC     (`W_ADC + `OSM_MAX)   // filter accumulator, room for 2^8 samples
`define W_ADR     4                     // wishbone register address

// register map
`define REG_CTRL  4'd0                  // activate [1:0], lock [9:8]
`define REG_OSM   4'd1
`define REG_SETP  4'd2
`define REG_PCOEF 4'd3
`define REG_ICOEF 4'd4
`define REG_DCOEF 4'd5
`define REG_MULT  4'd6
`define REG_SHIFT 4'd7
`define REG_MIN   4'd8
`define REG_MAX   4'd9
`define REG_INIT  4'd10

`endif

// ==== logic/pid_pkg.sv ====
`include "pid_params.svh"

package pid_pkg;

	// adc sample, also the filter output
	typedef struct packed {
		logic                     valid;
		logic signed [`W_ADC-1:0] data;
	} sample_t;

	// pid sum handed to the output stage
	typedef struct packed {
		logic                      valid;
		logic signed [`W_COMP-1:0] sum;
	} pid_word_t;

	// parallel dac word per channel
	typedef struct packed {
		logic                     valid;
		logic signed [`W_DAC-1:0] data;
	} dac_word_t;

	////////////////////////////////////////////////////////////////////////////
	// wishbone classic
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		logic [`W_ADR-1:0] adr;
		logic [`W_EP-1:0]  dat;   // write data
	} wb_req_t;

	typedef struct packed {
		logic             ack;
		logic [`W_EP-1:0] dat;    // read data, valid with ack
	} wb_rsp_t;

	// servo configuration, shared by every channel except the bit vectors
	typedef struct packed {
		logic [`N_CHAN-1:0] activate;   // filter enable per channel
		logic [`N_CHAN-1:0] lock;       // lock enable per channel
		logic [3:0]         osm;        // oversample exponent, saturated at 8
		logic signed [15:0] setpoint;
		logic signed [15:0] p_coef;
		logic signed [15:0] i_coef;
		logic signed [15:0] d_coef;
		logic signed [15:0] mult;       // output scale
		logic [3:0]         shift;      // right shift after scaling
		logic signed [15:0] out_min;
		logic signed [15:0] out_max;
		logic signed [15:0] out_init;   // output while unlocked
	} servo_cfg_t;

endpackage

// ==== logic/pid_param_bank.sv ====
`timescale 1ns/1ns
`include "pid_params.svh"

module pid_param_bank (
	input  logic                 clk50,
	input  logic                 arst_n,
	input  pid_pkg::wb_req_t     wb_i,
	output pid_pkg::wb_rsp_t     wb_o,
	output pid_pkg::servo_cfg_t  cfg
);

	localparam logic [3:0] OSM_SAT = `OSM_MAX;   // ceiling for the exponent

	logic             ack;
	logic             req;                       // new access seen this cycle
	logic             wr_en;
	logic [3:0]       osm_sat;                   // host osm after saturation
	logic [`W_EP-1:0] rd_mux;                    // decoded read word
	logic [`W_EP-1:0] rd_dat;                    // held for the ack cycle

	// the ack cycle itself never starts another access
	assign req   = wb_i.cyc & wb_i.stb & ~ack;
	assign wr_en = req & wb_i.we;

	assign osm_sat = (wb_i.dat > `OSM_MAX) ? OSM_SAT : wb_i.dat[3:0];

	////////////////////////////////////////////////////////////////////////////
	// read decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		rd_mux = '0;                             // unmapped reads as zero
		case (wb_i.adr)
			`REG_CTRL: begin
				rd_mux[`N_CHAN-1:0]  = cfg.activate;
				rd_mux[8 +: `N_CHAN] = cfg.lock;
			end
			`REG_OSM:   rd_mux[3:0] = cfg.osm;
			`REG_SETP:  rd_mux      = cfg.setpoint;
			`REG_PCOEF: rd_mux      = cfg.p_coef;
			`REG_ICOEF: rd_mux      = cfg.i_coef;
			`REG_DCOEF: rd_mux      = cfg.d_coef;
			`REG_MULT:  rd_mux      = cfg.mult;
			`REG_SHIFT: rd_mux[3:0] = cfg.shift;
			`REG_MIN:   rd_mux      = cfg.out_min;
			`REG_MAX:   rd_mux      = cfg.out_max;
			`REG_INIT:  rd_mux      = cfg.out_init;
			default:    ;
		endcase
	end

	always_ff @(posedge clk50) begin
		if (req)
			rd_dat <= rd_mux;                    // sampled with the request
	end

	////////////////////////////////////////////////////////////////////////////
	// ack and register writes
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			ack      <= 1'b0;
			cfg      <= '0;
			cfg.mult <= 16'sd1;                  // unity gain out of reset
		end else begin
			ack <= req;                          // single cycle pulse
			if (wr_en) begin
				// new value is live in the ack cycle
				case (wb_i.adr)
					`REG_CTRL: begin
						cfg.activate <= wb_i.dat[`N_CHAN-1:0];
						cfg.lock     <= wb_i.dat[8 +: `N_CHAN];
					end
					`REG_OSM:   cfg.osm      <= osm_sat;
					`REG_SETP:  cfg.setpoint <= wb_i.dat;
					`REG_PCOEF: cfg.p_coef   <= wb_i.dat;
					`REG_ICOEF: cfg.i_coef   <= wb_i.dat;
					`REG_DCOEF: cfg.d_coef   <= wb_i.dat;
					`REG_MULT:  cfg.mult     <= wb_i.dat;
					`REG_SHIFT: cfg.shift    <= wb_i.dat[3:0];
					`REG_MIN:   cfg.out_min  <= wb_i.dat;
					`REG_MAX:   cfg.out_max  <= wb_i.dat;
					`REG_INIT:  cfg.out_init <= wb_i.dat;
					default:    ;                // unmapped, dropped
				endcase
			end
		end
	end

	assign wb_o.ack = ack;
	assign wb_o.dat = rd_dat;

	// one ack per access, the master must see it drop
	a_ack_pulse : assert property (@(posedge clk50) disable iff (!arst_n)
		wb_o.ack |=> !wb_o.ack)
		else $error("wishbone ack held for two cycles");

endmodule

// ==== logic/oversample_filter.sv ====
`timescale 1ns/1ns
`include "pid_params.svh"

module oversample_filter (
	input  logic              clk50,
	input  logic              arst_n,
	input  logic              activate,     // channel enable
	input  logic [3:0]        osm,          // window is 2^osm samples
	input  pid_pkg::sample_t  sample_in,
	output pid_pkg::sample_t  sample_out
);

	logic [`OSM_MAX:0]        count;        // samples taken this window
	logic [`OSM_MAX:0]        count_inc;
	logic [`OSM_MAX:0]        win_len;
	logic signed [`W_ACC-1:0] acc;          // running window sum
	logic signed [`W_ACC-1:0] sample_ext;
	logic signed [`W_ACC-1:0] acc_next;
	logic signed [`W_ACC-1:0] mean;         // sum over 2^osm
	logic                     last;         // sample closes the window
	logic                     out_valid;
	logic [`W_ADC-1:0]        out_data;

	assign win_len    = 1'b1 << osm;
	assign count_inc  = count + 1'b1;
	assign sample_ext = sample_in.data;     // sign extend
	assign acc_next   = acc + sample_ext;
	assign mean       = acc_next >>> osm;   // arithmetic, rounds toward -inf

	// >= so a shrinking osm mid window still closes it
	assign last = sample_in.valid && (count_inc >= win_len);

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			count     <= '0;
			acc       <= '0;
			out_valid <= 1'b0;
		end else if (!activate) begin
			count     <= '0;                // idle, nothing accumulates
			acc       <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= last;
			if (last) begin
				count <= '0;                // restart next window
				acc   <= '0;
			end else if (sample_in.valid) begin
				count <= count_inc;
				acc   <= acc_next;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (last)
			out_data <= mean[`W_ADC-1:0];   // mean fits the sample width
	end

	assign sample_out.valid = out_valid;
	assign sample_out.data  = out_data;

	a_count_range : assert property (@(posedge clk50) disable iff (!arst_n)
		count <= (1 << `OSM_MAX))
		else $error("oversample count past largest window");

endmodule

// ==== logic/pid_core.sv ====
`timescale 1ns/1ns
`include "pid_params.svh"

module pid_core (
	input  logic               clk50,
	input  logic               arst_n,
	input  logic               lock,          // low clears integral and history
	input  logic signed [15:0] setpoint,
	input  logic signed [15:0] p_coef,
	input  logic signed [15:0] i_coef,
	input  logic signed [15:0] d_coef,
	input  pid_pkg::sample_t   sample_in,
	output pid_pkg::pid_word_t sum_out
);

	logic signed [`W_COMP-1:0] setp_ext;
	logic signed [`W_COMP-1:0] samp_ext;
	logic signed [`W_COMP-1:0] p_ext;
	logic signed [`W_COMP-1:0] i_ext;
	logic signed [`W_COMP-1:0] d_ext;
	logic signed [`W_COMP-1:0] error;
	logic signed [`W_COMP-1:0] prev_error;    // error of the last valid sample
	logic signed [`W_COMP-1:0] integral;
	logic signed [`W_COMP-1:0] integral_next;
	logic signed [`W_COMP-1:0] deriv;
	logic signed [`W_COMP-1:0] sum;
	logic                      out_valid;
	logic signed [`W_COMP-1:0] out_sum;

	// everything widened to the computation width first
	assign setp_ext = setpoint;
	assign samp_ext = sample_in.data;
	assign p_ext    = p_coef;
	assign i_ext    = i_coef;
	assign d_ext    = d_coef;

	////////////////////////////////////////////////////////////////////////////
	// pid terms
	////////////////////////////////////////////////////////////////////////////

	assign error         = setp_ext - samp_ext;
	assign integral_next = integral + error;       // includes this sample
	assign deriv         = error - prev_error;
	assign sum           = p_ext * error + i_ext * integral_next + d_ext * deriv;

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n) begin
			integral   <= '0;
			prev_error <= '0;
			out_valid  <= 1'b0;
		end else begin
			out_valid <= sample_in.valid;          // unlocked samples still flow
			if (!lock) begin
				integral   <= '0;                  // restart clean on relock
				prev_error <= '0;
			end else if (sample_in.valid) begin
				integral   <= integral_next;
				prev_error <= error;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (sample_in.valid)
			out_sum <= sum;
	end

	assign sum_out.valid = out_valid;
	assign sum_out.sum   = out_sum;

	a_one_cycle : assert property (@(posedge clk50) disable iff (!arst_n)
		sum_out.valid |-> $past(sample_in.valid))
		else $error("pid sum valid without input one cycle earlier");

endmodule

// ==== logic/output_preprocessor.sv ====
`timescale 1ns/1ns
`include "pid_params.svh"

module output_preprocessor (
	input  logic               clk50,
	input  logic               arst_n,
	input  logic               lock,         // low holds the output at init
	input  logic signed [15:0] mult,
	input  logic [3:0]         shift,
	input  logic signed [15:0] out_min,
	input  logic signed [15:0] out_max,
	input  logic signed [15:0] out_init,
	input  pid_pkg::pid_word_t sum_in,
	output pid_pkg::dac_word_t dac_out
);

	logic signed [`W_COMP-1:0] mult_ext;
	logic signed [`W_COMP-1:0] min_ext;
	logic signed [`W_COMP-1:0] max_ext;
	logic signed [`W_COMP-1:0] product;
	logic signed [`W_COMP-1:0] scaled;       // after the right shift
	logic signed [`W_DAC-1:0]  clamped;
	logic                      out_valid;
	logic signed [`W_DAC-1:0]  out_data;

	assign mult_ext = mult;
	assign min_ext  = out_min;
	assign max_ext  = out_max;
	assign product  = sum_in.sum * mult_ext;
	assign scaled   = product >>> shift;     // shift stands in for a divisor

	always_comb begin
		if (scaled > max_ext)
			clamped = out_max;
		else if (scaled < min_ext)
			clamped = out_min;
		else
			clamped = scaled[`W_DAC-1:0];    // in range, fits the dac word
	end

	always_ff @(posedge clk50 or negedge arst_n) begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= sum_in.valid;
	end

	always_ff @(posedge clk50) begin
		if (sum_in.valid)
			out_data <= lock ? clamped : out_init;
	end

	assign dac_out.valid = out_valid;
	assign dac_out.data  = out_data;

	// limits and lock as they were when the word was computed
	a_in_limits : assert property (@(posedge clk50) disable iff (!arst_n)
		(dac_out.valid && $past(lock) && ($past(out_min) <= $past(out_max)))
		|-> (dac_out.data >= $past(out_min) && dac_out.data <= $past(out_max)))
		else $error("dac word outside min and max while locked");

endmodule

// ==== logic/pid_controller.sv ====
`timescale 1ns/1ns
`include "pid_params.svh"

module pid_controller (
	input  logic                clk50,                // system clock
	input  logic                arst_n,
	input  pid_pkg::sample_t    samples [`N_CHAN],    // parallel adc samples
	input  pid_pkg::wb_req_t    wb_i,                 // host bus
	output pid_pkg::wb_rsp_t    wb_o,
	output pid_pkg::dac_word_t  dac [`N_CHAN]         // signed dac words
);

	pid_pkg::servo_cfg_t cfg;                         // live configuration
	pid_pkg::sample_t    osf_out [`N_CHAN];           // averaged samples
	pid_pkg::pid_word_t  pid_out [`N_CHAN];           // raw pid sums

	////////////////////////////////////////////////////////////////////////////
	// register bank
	////////////////////////////////////////////////////////////////////////////

	pid_param_bank u_bank (
		.clk50  (clk50),
		.arst_n (arst_n),
		.wb_i   (wb_i),
		.wb_o   (wb_o),
		.cfg    (cfg)
	);

	////////////////////////////////////////////////////////////////////////////
	// servo channels, fixed channel to output mapping
	////////////////////////////////////////////////////////////////////////////

	for (genvar c = 0; c < `N_CHAN; c++) begin : g_chan
		oversample_filter u_osf (
			.clk50      (clk50),
			.arst_n     (arst_n),
			.activate   (cfg.activate[c]),
			.osm        (cfg.osm),
			.sample_in  (samples[c]),
			.sample_out (osf_out[c])
		);

		pid_core u_pid (
			.clk50     (clk50),
			.arst_n    (arst_n),
			.lock      (cfg.lock[c]),
			.setpoint  (cfg.setpoint),
			.p_coef    (cfg.p_coef),
			.i_coef    (cfg.i_coef),
			.d_coef    (cfg.d_coef),
			.sample_in (osf_out[c]),
			.sum_out   (pid_out[c])
		);

		output_preprocessor u_opp (
			.clk50    (clk50),
			.arst_n   (arst_n),
			.lock     (cfg.lock[c]),               // same lock as the pid core
			.mult     (cfg.mult),
			.shift    (cfg.shift),
			.out_min  (cfg.out_min),
			.out_max  (cfg.out_max),
			.out_init (cfg.out_init),
			.sum_in   (pid_out[c]),
			.dac_out  (dac[c])
		);
	end

endmodule

// ==== tests/pid_controller_tb.sv ====
`timescale 1ns/1ns
`include "pid_params.svh"

module pid_controller_tb;

	localparam int ACK_WAIT   = 16;           // cycles allowed for a wishbone ack
	localparam int DRAIN_WAIT = 64;           // cycles allowed to empty the pipeline

	logic               clk50 = 1'b0;
	logic               arst_n;
	pid_pkg::sample_t   samples [`N_CHAN];
	pid_pkg::wb_req_t   wb_i;
	pid_pkg::wb_rsp_t   wb_o;
	pid_pkg::dac_word_t dac [`N_CHAN];

	int cycle      = 0;                       // rising edges so far
	int err_cnt    = 0;
	int reg_checks = 0;
	int words_cnt  = 0;
	int tests_run  = 0;

	// reference model
	logic [15:0]        m_reg [16] = '{default: 16'h0000};  // expected register contents
	longint             m_acc [`N_CHAN] = '{default: 0};
	int                 m_cnt [`N_CHAN] = '{default: 0};
	longint             m_integ [`N_CHAN] = '{default: 0};
	longint             m_prev [`N_CHAN] = '{default: 0};
	int                 exp_q [`N_CHAN][$];  // expected words with the oldest first
	int                 due_q [`N_CHAN][$];  // cycle each word is due
	logic               exp_have [`N_CHAN] = '{default: 1'b0};
	logic signed [15:0] exp_front [`N_CHAN];
	int                 exp_due [`N_CHAN];

	pid_controller u_dut (
		.clk50   (clk50),
		.arst_n  (arst_n),
		.samples (samples),
		.wb_i    (wb_i),
		.wb_o    (wb_o),
		.dac     (dac)
	);

	always #2 clk50 = ~clk50;                 // 4 ns period
	always @(posedge clk50) cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// output checking
	////////////////////////////////////////////////////////////////////////////

	// head of queue staged on the falling edge and checked on the next rising edge
	always @(negedge clk50) begin
		for (int c = 0; c < `N_CHAN; c++) begin
			exp_have[c] = dac[c].valid && (exp_q[c].size() > 0);
			if (exp_have[c]) begin
				exp_front[c] = 16'(exp_q[c].pop_front());
				exp_due[c]   = due_q[c].pop_front();
				words_cnt++;
			end
		end
	end

	for (genvar c = 0; c < `N_CHAN; c++) begin : g_check
		a_dac_expected : assert property (@(posedge clk50) disable iff (!arst_n)
			dac[c].valid |-> exp_have[c])
			else begin
				$display("dac[%0d] put out a word that no window produced", c);
				err_cnt++;
			end
		a_dac_value : assert property (@(posedge clk50) disable iff (!arst_n)
			dac[c].valid && exp_have[c] |-> dac[c].data == exp_front[c])
			else begin
				$display("Fail dac[%0d].data got %h expected %h", c,
					$sampled(dac[c].data), exp_front[c]);
				err_cnt++;
			end
		a_dac_latency : assert property (@(posedge clk50) disable iff (!arst_n)
			dac[c].valid && exp_have[c] |-> cycle == exp_due[c])
			else begin
				$display("Fail dac[%0d].valid cycle got %h expected %h", c,
					$sampled(cycle), exp_due[c]);
				err_cnt++;
			end
	end

	////////////////////////////////////////////////////////////////////////////
	// register map and servo rules
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] expected_read(input int adr, input logic [15:0] dat);
		case (adr)
			`REG_CTRL:  return dat & 16'h0303;           // activate and lock bits only
			`REG_OSM:   return (dat > `OSM_MAX) ? 16'(`OSM_MAX) : dat;
			`REG_SHIFT: return dat & 16'h000f;
			default:    return (adr <= `REG_INIT) ? dat : 16'h0000;
		endcase
	endfunction

	function automatic longint reg_s(input int adr);
		return longint'($signed(m_reg[adr]));           // coefficients are signed
	endfunction

	// feeds channel c one valid sample and queues a word when a window closes
	function automatic void model_sample(input int c, input longint x);
		longint mean;
		longint err;
		longint sum;
		longint word;
		if (!m_reg[`REG_CTRL][c])
			return;                                      // filter idle
		m_acc[c] += x;
		m_cnt[c]++;
		if (m_cnt[c] < (1 << m_reg[`REG_OSM]))
			return;
		mean     = m_acc[c] >>> m_reg[`REG_OSM];
		m_acc[c] = 0;
		m_cnt[c] = 0;
		err      = reg_s(`REG_SETP) - mean;
		if (m_reg[`REG_CTRL][8+c]) begin
			m_integ[c] += err;
			sum = reg_s(`REG_PCOEF) * err + reg_s(`REG_ICOEF) * m_integ[c]
				+ reg_s(`REG_DCOEF) * (err - m_prev[c]);
			m_prev[c] = err;
			word = (sum * reg_s(`REG_MULT)) >>> m_reg[`REG_SHIFT];
			if (word > reg_s(`REG_MAX))
				word = reg_s(`REG_MAX);
			else if (word < reg_s(`REG_MIN))
				word = reg_s(`REG_MIN);
		end else
			word = reg_s(`REG_INIT);                     // unlocked holds init
		exp_q[c].push_back(int'(word));
		due_q[c].push_back(cycle + 3);                   // filter, pid, output stage
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// bus and stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic wb_access(input logic we, input logic [3:0] adr,
		input logic [15:0] wdat, output logic [15:0] rdat);
		int waited;
		waited = 0;
		wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		@(negedge clk50);
		while (!wb_o.ack && waited < ACK_WAIT) begin
			waited++;
			@(negedge clk50);
		end
		if (!wb_o.ack) begin
			abort_run("wishbone access timed out without an ack");
		end else begin
			rdat = wb_o.dat;
			wb_i = '0;                                   // end of cycle
			@(negedge clk50);
			assert (!wb_o.ack) else begin
				$display("Fail wb_o.ack got %h expected %h", wb_o.ack, 1'b0);
				err_cnt++;
			end
		end
	endtask

	task automatic write_reg(input logic [3:0] adr, input logic [15:0] dat);
		logic [15:0] unused;
		wb_access(1'b1, adr, dat, unused);
		m_reg[adr] = expected_read(adr, dat);
		for (int c = 0; c < `N_CHAN; c++) begin
			if (!m_reg[`REG_CTRL][8+c]) begin            // unlocked clears pid state
				m_integ[c] = 0;
				m_prev[c]  = 0;
			end
			if (!m_reg[`REG_CTRL][c]) begin
				m_acc[c] = 0;
				m_cnt[c] = 0;
			end
		end
	endtask

	task automatic read_check(input logic [3:0] adr);
		logic [15:0] rd;
		wb_access(1'b0, adr, 16'h0000, rd);
		reg_checks++;
		assert (rd == m_reg[adr]) else begin
			$display("Fail wb_o.dat at %h got %h expected %h", adr, rd, m_reg[adr]);
			err_cnt++;
		end
	endtask

	task automatic set_gains(input int setp, input int p, input int i, input int d);
		write_reg(`REG_SETP, 16'(setp));
		write_reg(`REG_PCOEF, 16'(p));
		write_reg(`REG_ICOEF, 16'(i));
		write_reg(`REG_DCOEF, 16'(d));
	endtask

	task automatic set_output(input int mult, input int shift, input int lo, input int hi,
		input int init);
		write_reg(`REG_MULT, 16'(mult));
		write_reg(`REG_SHIFT, 16'(shift));
		write_reg(`REG_MIN, 16'(lo));
		write_reg(`REG_MAX, 16'(hi));
		write_reg(`REG_INIT, 16'(init));
	endtask

	task automatic send_pair(input int x0, input int x1);
		samples[0] = '{valid: 1'b1, data: `W_ADC'(x0)};
		samples[1] = '{valid: 1'b1, data: `W_ADC'(x1)};
		model_sample(0, x0);
		model_sample(1, x1);
		@(negedge clk50);
		samples[0].valid = 1'b0;
		samples[1].valid = 1'b0;
	endtask

	// back to back windows of random or constant samples
	task automatic send_windows(input int n_win, input bit rnd, input int k0, input int k1);
		int x0;
		int x1;
		repeat (n_win * (1 << m_reg[`REG_OSM])) begin
			x0 = rnd ? int'($urandom_range(16383)) - 8192 : k0;
			x1 = rnd ? int'($urandom_range(16383)) - 8192 : k1;
			send_pair(x0, x1);
		end
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while (exp_q[0].size() + exp_q[1].size() > 0 && waited < DRAIN_WAIT) begin
			waited++;
			@(negedge clk50);
		end
		if (exp_q[0].size() + exp_q[1].size() > 0) begin
			abort_run("expected dac words never came out of the pipeline");
		end else begin
			repeat (4) @(negedge clk50);                 // room for stray words
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		$display("%s done, %0d errors", name, err_cnt - errs_before);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int errs;
		int osm_list [3];
		void'($urandom(32'h1b6fd590));
		osm_list   = '{0, 2, 3};
		arst_n     = 1'b0;
		wb_i       = '0;
		samples[0] = '0;
		samples[1] = '0;
		m_reg[`REG_MULT] = 16'h0001;                     // unity gain out of reset
		repeat (2) @(posedge clk50);
		@(negedge clk50);
		arst_n = 1'b1;

		errs = err_cnt;
		assert (!wb_o.ack) else begin
			$display("Fail wb_o.ack got %h expected %h", wb_o.ack, 1'b0);
			err_cnt++;
		end
		for (int a = 0; a < 16; a++) begin               // unmapped ones too
			write_reg(4'(a), 16'hc35a ^ (16'(a) * 16'h1111));
			read_check(4'(a));
		end
		finish_test("register access", errs);

		errs = err_cnt;
		write_reg(`REG_CTRL, 16'h0303);
		set_gains(0, 1, 0, 0);
		set_output(1, 0, -32768, 32767, 0);
		foreach (osm_list[k]) begin
			write_reg(`REG_OSM, 16'(osm_list[k]));
			send_windows(4, 1'b1, 0, 0);
			drain_pipeline();
		end
		finish_test("oversample averaging", errs);

		errs = err_cnt;
		write_reg(`REG_CTRL, 16'h0003);                  // drop lock to clear history
		write_reg(`REG_CTRL, 16'h0303);
		set_gains(100, 1, 2, 3);
		write_reg(`REG_OSM, 16'd2);
		send_windows(6, 1'b0, 40, -25);
		drain_pipeline();
		finish_test("integral and derivative", errs);

		errs = err_cnt;
		set_gains(0, 1, 0, 0);
		set_output(3, 2, -500, 700, 0);
		write_reg(`REG_OSM, 16'd0);
		send_pair(20000, -20000);                        // both rails and then in range
		send_pair(-20000, 20000);
		send_pair(100, -100);
		send_pair(-37, 37);
		drain_pipeline();
		finish_test("scaling and clamping", errs);

		errs = err_cnt;
		set_output(1, 0, -32768, 32767, 16'h1234);
		write_reg(`REG_CTRL, 16'h0003);                  // active and unlocked
		write_reg(`REG_OSM, 16'd2);
		send_windows(3, 1'b1, 0, 0);
		drain_pipeline();
		set_gains(50, 0, 1, 0);
		write_reg(`REG_CTRL, 16'h0303);                  // integral starts at zero
		send_windows(3, 1'b0, 10, 20);
		drain_pipeline();
		write_reg(`REG_CTRL, 16'h0301);                  // channel 1 idle
		send_windows(3, 1'b1, 0, 0);
		drain_pipeline();
		finish_test("lock and activation", errs);

		$display("tests %0d, register checks %0d, dac words %0d, errors %0d",
			tests_run, reg_checks, words_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== pid_controller.f ====
+incdir+logic
logic/pid_pkg.sv
logic/pid_param_bank.sv
logic/oversample_filter.sv
logic/pid_core.sv
logic/output_preprocessor.sv
logic/pid_controller.sv
tests/pid_controller_tb.sv

// ==== Makefile ====
# verilator build and run of the pid controller testbench
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f pid_controller.f \
		--top-module pid_controller_tb -o pid_controller_sim

run: compile
	@out=$$(./obj_dir/pid_controller_sim); echo "$$out"; \
		echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
